// File: rtl/spiMemPkg.sv
// Widths, debounce and fetch constants, controller state enum and shared structs
package spiMemPkg;

   // ----------------------------------------
   // Widths
   // ----------------------------------------
   localparam int addrWidth = 7;
   localparam int dataWidth = 8;
   // One byte per address value
   localparam int memDepth = 1 << addrWidth;
   // Counts 0..dataWidth inclusive
   localparam int bitCountWidth = $clog2(dataWidth + 1);

   // ----------------------------------------
   // Input conditioning and read timing
   // ----------------------------------------
   // Cycles a new level must persist
   localparam int debounceCycles = 3;
   localparam int debounceCountWidth = $clog2(debounceCycles + 1);
   // Address-to-load wait in readFetch
   localparam int fetchLatency = 2;

   // Frame FSM states
   typedef enum logic [2:0] {
      idle,
      address,
      readFetch,
      readShift,
      writeData,
      finished
   } ctrlState_t;

   // One conditioned pin
   typedef struct packed {
      logic level;
      logic rise;
      logic fall;
   } pinState_t;

   // Controller to shift register
   typedef struct packed {
      logic load;
      logic shift;
      logic drive;
   } shiftCtrl_t;

   // Controller to memory
   typedef struct packed {
      logic [addrWidth-1:0] addr;
      logic                 we;
   } memReq_t;

endpackage

// File: rtl/inputConditioner.sv
// Two-flop synchronizer, counter debouncer and edge pulse generator for one pin
`timescale 1ns/1ps

module inputConditioner (
   input  logic                 clk,
   input  logic                 arstN,
   input  logic                 pin,
   output spiMemPkg::pinState_t state
);

   // Synchronizer stages
   logic syncFirst;
   logic syncSecond;
   // Debounced level and its delayed copy
   logic levelQ;
   logic levelDly;
   logic riseQ;
   logic fallQ;
   logic [spiMemPkg::debounceCountWidth-1:0] stableCount;

   // ----------------------------------------
   // Synchronize and debounce
   // ----------------------------------------
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         syncFirst   <= 1'b0;
         syncSecond  <= 1'b0;
         levelQ      <= 1'b0;
         stableCount <= '0;
      end else begin
         syncFirst  <= pin;
         syncSecond <= syncFirst;
         if (syncSecond == levelQ) begin
            // Glitch gone or nothing pending
            stableCount <= '0;
         end else if (int'(stableCount) == spiMemPkg::debounceCycles) begin
            levelQ      <= syncSecond;
            stableCount <= '0;
         end else begin
            stableCount <= stableCount + 1'b1;
         end
      end
   end

   // ----------------------------------------
   // Edge pulses, one cycle after level moves
   // ----------------------------------------
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         levelDly <= 1'b0;
         riseQ    <= 1'b0;
         fallQ    <= 1'b0;
      end else begin
         levelDly <= levelQ;
         riseQ    <= levelQ & ~levelDly;
         fallQ    <= ~levelQ & levelDly;
      end
   end

   assign state.level = levelQ;
   assign state.rise  = riseQ;
   assign state.fall  = fallQ;

   // Opposite edges can never be reported together
   assert property (@(posedge clk) disable iff (!arstN) !(state.rise && state.fall));

endmodule

// File: rtl/shiftRegister.sv
// Byte shift register with serial in, parallel load and falling-edge MISO register
`timescale 1ns/1ps

module shiftRegister (
   input  logic                              clk,
   input  logic                              arstN,
   input  spiMemPkg::shiftCtrl_t             ctrl,
   input  logic                              sclkFall,
   input  logic                              serialIn,
   input  logic [spiMemPkg::dataWidth-1:0]   loadData,
   output logic [spiMemPkg::dataWidth-1:0]   parallelOut,
   output logic                              miso,
   output logic                              misoEn
);

   logic [spiMemPkg::dataWidth-1:0] data;
   logic misoQ;
   logic misoEnQ;
   // Present next read bit
   logic driveStep;

   assign driveStep = sclkFall && ctrl.drive && !ctrl.load;

   // ----------------------------------------
   // Byte register
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (ctrl.load) begin
         // Memory byte for the read phase
         data <= loadData;
      end else if (ctrl.shift) begin
         // MSB first from MOSI
         data <= {data[spiMemPkg::dataWidth-2:0], serialIn};
      end else if (driveStep) begin
         data <= {data[spiMemPkg::dataWidth-2:0], 1'b0};
      end
   end

   // ----------------------------------------
   // MISO output stage
   // ----------------------------------------
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         misoQ   <= 1'b0;
         misoEnQ <= 1'b0;
      end else begin
         misoEnQ <= ctrl.drive;
         // Held steady across the master's rising edge
         if (driveStep) begin
            misoQ <= data[spiMemPkg::dataWidth-1];
         end
      end
   end

   assign parallelOut = data;
   assign miso        = misoQ;
   assign misoEn      = misoEnQ;

   // Controller never loads and shifts at once
   assert property (@(posedge clk) disable iff (!arstN) !(ctrl.load && ctrl.shift));

endmodule

// File: rtl/dataMemory.sv
// Byte memory with synchronous write and registered read
`timescale 1ns/1ps

module dataMemory (
   input  logic                              clk,
   input  spiMemPkg::memReq_t                req,
   input  logic [spiMemPkg::dataWidth-1:0]   wrData,
   output logic [spiMemPkg::dataWidth-1:0]   rdData
);

   // Storage array, block RAM shaped
   logic [spiMemPkg::dataWidth-1:0] mem [spiMemPkg::memDepth];
   logic [spiMemPkg::dataWidth-1:0] rdQ;

   // ----------------------------------------
   // Write port
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (req.we) begin
         mem[req.addr] <= wrData;
      end
   end

   // ----------------------------------------
   // Read port
   // ----------------------------------------
   // Valid one cycle after addr
   always_ff @(posedge clk) begin
      rdQ <= mem[req.addr];
   end

   assign rdData = rdQ;

endmodule

// File: rtl/spiController.sv
// Frame FSM, bit counter and address latch for the SPI byte memory
`timescale 1ns/1ps

module spiController (
   input  logic                              clk,
   input  logic                              arstN,
   input  spiMemPkg::pinState_t              sclk,
   input  spiMemPkg::pinState_t              csN,
   input  logic [spiMemPkg::dataWidth-1:0]   parallelIn,
   output spiMemPkg::shiftCtrl_t             shiftCtrl,
   output spiMemPkg::memReq_t                memReq
);

   spiMemPkg::ctrlState_t state;
   spiMemPkg::ctrlState_t nextState;
   // Bit count, reused as fetch wait
   logic [spiMemPkg::bitCountWidth-1:0] bitCount;
   logic [spiMemPkg::addrWidth-1:0] addrQ;
   // Full byte received
   logic countDone;
   // Memory data ready to load
   logic fetchDone;
   // States that take MOSI bits
   logic shifting;
   logic readFlag;

   assign countDone = int'(bitCount) == spiMemPkg::dataWidth;
   assign fetchDone = int'(bitCount) == spiMemPkg::fetchLatency;
   assign shifting  = (state == spiMemPkg::address || state == spiMemPkg::writeData)
                      && !countDone;
   // Eighth address bit is R/W, 1 means read
   assign readFlag  = parallelIn[0];

   // ----------------------------------------
   // Next state
   // ----------------------------------------
   always_comb begin
      nextState = state;
      case (state)
         spiMemPkg::idle: begin
            // Frame starts on CS falling
            if (csN.fall) begin
               nextState = spiMemPkg::address;
            end
         end
         spiMemPkg::address: begin
            if (countDone) begin
               nextState = readFlag ? spiMemPkg::readFetch : spiMemPkg::writeData;
            end
         end
         spiMemPkg::readFetch: begin
            if (fetchDone) begin
               nextState = spiMemPkg::readShift;
            end
         end
         spiMemPkg::writeData: begin
            if (countDone) begin
               nextState = spiMemPkg::finished;
            end
         end
         // readShift and finished hold until CS rises
         spiMemPkg::readShift,
         spiMemPkg::finished: begin
            nextState = state;
         end
         default: begin
            nextState = spiMemPkg::idle;
         end
      endcase
      // CS high ends or aborts any frame
      if (csN.rise) begin
         nextState = spiMemPkg::idle;
      end
   end

   // ----------------------------------------
   // State, counter and address latch
   // ----------------------------------------
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state    <= spiMemPkg::idle;
         bitCount <= '0;
         addrQ    <= '0;
      end else begin
         state <= nextState;
         if (nextState != state) begin
            // Fresh count in every new state
            bitCount <= '0;
         end else if ((shifting && sclk.rise) || state == spiMemPkg::readFetch) begin
            bitCount <= bitCount + 1'b1;
         end
         // Address sits above the flag bit
         if (state == spiMemPkg::address && countDone) begin
            addrQ <= parallelIn[spiMemPkg::dataWidth-1:1];
         end
      end
   end

   // ----------------------------------------
   // Outputs
   // ----------------------------------------
   always_comb begin
      shiftCtrl.shift = shifting && sclk.rise;
      shiftCtrl.load  = (state == spiMemPkg::readFetch) && fetchDone;
      shiftCtrl.drive = (state == spiMemPkg::readShift);
      memReq.addr     = addrQ;
      // Single write strobe per frame
      memReq.we       = (state == spiMemPkg::writeData) && countDone;
   end

   // Read and write phases never overlap
   assert property (@(posedge clk) disable iff (!arstN)
      !(memReq.we && shiftCtrl.drive));

   // Write strobe only in writeData, and only for one cycle
   assert property (@(posedge clk) disable iff (!arstN)
      memReq.we |-> (state == spiMemPkg::writeData) ##1 !memReq.we);

endmodule

// File: rtl/spiMemory.sv
// Top level of the SPI byte memory: pin conditioners, controller, shift register, RAM
`timescale 1ns/1ps

module spiMemory (
   input  logic clk,
   input  logic arstN,
   input  logic sclkPin,
   input  logic csNPin,
   input  logic mosiPin,
   output logic miso,
   output logic misoEn
);

   // Conditioned pins
   spiMemPkg::pinState_t sclkState;
   spiMemPkg::pinState_t csNState;
   spiMemPkg::pinState_t mosiState;
   // Controller outputs
   spiMemPkg::shiftCtrl_t shiftCtrl;
   spiMemPkg::memReq_t memReq;
   // Byte paths
   logic [spiMemPkg::dataWidth-1:0] parallelData;
   logic [spiMemPkg::dataWidth-1:0] memRdData;

   // ----------------------------------------
   // Pin conditioning
   // ----------------------------------------
   inputConditioner sclkCond (.clk(clk), .arstN(arstN), .pin(sclkPin), .state(sclkState));
   inputConditioner csNCond  (.clk(clk), .arstN(arstN), .pin(csNPin),  .state(csNState));
   inputConditioner mosiCond (.clk(clk), .arstN(arstN), .pin(mosiPin), .state(mosiState));

   // ----------------------------------------
   // Frame control
   // ----------------------------------------
   spiController ctrl (
      .clk       (clk),
      .arstN     (arstN),
      .sclk      (sclkState),
      .csN       (csNState),
      .parallelIn(parallelData),
      .shiftCtrl (shiftCtrl),
      .memReq    (memReq)
   );

   // Serial data path
   shiftRegister shiftReg (
      .clk        (clk),
      .arstN      (arstN),
      .ctrl       (shiftCtrl),
      .sclkFall   (sclkState.fall),
      .serialIn   (mosiState.level),
      .loadData   (memRdData),
      .parallelOut(parallelData),
      .miso       (miso),
      .misoEn     (misoEn)
   );

   // Storage, written from the shift register
   dataMemory mem (
      .clk   (clk),
      .req   (memReq),
      .wrData(parallelData),
      .rdData(memRdData)
   );

endmodule

// File: tb/spiMemoryModel.svh
// Reference byte memory model and SPI frame expectation functions
`ifndef SPI_MEMORY_MODEL_SVH
`define SPI_MEMORY_MODEL_SVH

// ----------------------------------------
// Model storage
// ----------------------------------------
// Expected contents, one byte per address
logic [spiMemPkg::dataWidth-1:0] modelMem [spiMemPkg::memDepth];
// Set once an address has seen a complete write
bit modelWritten [spiMemPkg::memDepth];

// Only complete write frames reach the model
function automatic void modelWrite(
   input logic [spiMemPkg::addrWidth-1:0] addr,
   input logic [spiMemPkg::dataWidth-1:0] data
);
   modelMem[addr]     = data;
   modelWritten[addr] = 1'b1;
endfunction

// Byte that a read frame must return
function automatic logic [spiMemPkg::dataWidth-1:0] expectedRead(
   input logic [spiMemPkg::addrWidth-1:0] addr
);
   return modelMem[addr];
endfunction

function automatic bit isWritten(input logic [spiMemPkg::addrWidth-1:0] addr);
   return modelWritten[addr];
endfunction

// Address in the upper seven bits and read flag in bit 0
function automatic logic [spiMemPkg::dataWidth-1:0] commandByte(
   input logic [spiMemPkg::addrWidth-1:0] addr,
   input logic                            isRead
);
   return {addr, isRead};
endfunction

`endif

// File: tb/spiMemoryTb.sv
// Testbench for the SPI byte memory with clock, reset, bit-banged frames, checks and summary
`timescale 1ns/1ps

module spiMemoryTb;

   `include "spiMemoryModel.svh"

   // SCLK half period in clocks exceeding every internal latency
   localparam int halfPeriod = 16;
   // Shorter than the debounce window
   localparam int glitchLen = spiMemPkg::debounceCycles - 1;
   // About 50 frames of roughly 560 cycles each plus reset and margin
   localparam int timeoutCycles = 60000;
   localparam int randomWrites = 20;
   // What the master samples at an SCLK rise
   localparam int kindNone = 0;
   localparam int kindAddr = 1;
   localparam int kindRead = 2;

   logic clk;
   logic arstN;
   logic sclkPin;
   logic csNPin;
   logic mosiPin;
   logic miso;
   logic misoEn;

   // Requests from the bit-banging tasks to the compare process
   logic sampleReq;
   int   sampleKind;
   logic writeWatch;
   logic glitchOn;
   logic [spiMemPkg::addrWidth-1:0] expAddr;
   logic [spiMemPkg::dataWidth-1:0] expByte;
   // Owned by the compare process
   logic [spiMemPkg::dataWidth-1:0] readByte = '0;
   int readBits = 0;
   int readsChecked = 0;
   int compareErrors = 0;
   // Owned by the main sequence
   int readsIssued;
   int directErrors;
   int testsRun;
   int testsFailed;
   int cycleCount = 0;

   spiMemory UUT (
      .clk    (clk),
      .arstN  (arstN),
      .sclkPin(sclkPin),
      .csNPin (csNPin),
      .mosiPin(mosiPin),
      .miso   (miso),
      .misoEn (misoEn)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Hard stop in case a frame never completes
   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= timeoutCycles) begin
         $display("Timeout after %0d cycles, the tests did not finish", cycleCount);
         $display("Verification failed");
         $finish;
      end
   end

   // ----------------------------------------
   // Compare process sampling at negedge
   // ----------------------------------------
   always @(negedge clk) begin
      if (sampleReq && sampleKind == kindAddr) begin
         // New frame starts a fresh byte
         readBits = 0;
         if (misoEn !== 1'b0) begin
            $display("MISMATCH at %0t: misoEn expected 0 got %b", $time, misoEn);
            compareErrors++;
         end
      end else if (sampleReq && sampleKind == kindRead) begin
         if (misoEn !== 1'b1) begin
            $display("MISMATCH at %0t: misoEn expected 1 got %b", $time, misoEn);
            compareErrors++;
         end
         readByte = {readByte[spiMemPkg::dataWidth-2:0], miso};
         readBits++;
         if (readBits == spiMemPkg::dataWidth) begin
            readsChecked++;
            if (readByte !== expByte) begin
               $display("MISMATCH at %0t: readByte expected %02h got %02h at address %02h",
                        $time, expByte, readByte, expAddr);
               compareErrors++;
            end
         end
      end
      // Write frames never enable MISO
      if (writeWatch && misoEn !== 1'b0) begin
         $display("MISMATCH at %0t: misoEn expected 0 got %b", $time, misoEn);
         compareErrors++;
      end
   end

   function automatic int totalErrors();
      return compareErrors + directErrors;
   endfunction

   // Returns 1 ns after a rising edge
   task automatic waitClocks(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   // ----------------------------------------
   // SPI mode 0 master
   // ----------------------------------------
   task automatic sendBit(input logic mosiVal, input int kind);
      mosiPin = mosiVal;
      if (glitchOn) begin
         // Short SCLK spike mid low half
         waitClocks(6);
         sclkPin = 1'b1;
         waitClocks(glitchLen);
         sclkPin = 1'b0;
         waitClocks(halfPeriod - 6 - glitchLen);
      end else begin
         waitClocks(halfPeriod);
      end
      sclkPin    = 1'b1;
      if (glitchOn) begin
         // MOSI spike on the sampling edge itself
         mosiPin = ~mosiVal;
      end
      sampleReq  = (kind != kindNone);
      sampleKind = kind;
      waitClocks(1);
      sampleReq = 1'b0;
      if (glitchOn) begin
         waitClocks(glitchLen - 1);
         mosiPin = mosiVal;
         // SCLK dropout mid high half
         waitClocks(8);
         sclkPin = 1'b0;
         waitClocks(glitchLen);
         sclkPin = 1'b1;
         waitClocks(halfPeriod - 8 - 2 * glitchLen);
      end else begin
         waitClocks(halfPeriod - 1);
      end
      // Falling edge where the slave presents the next MISO bit
      sclkPin = 1'b0;
   endtask

   task automatic startFrame();
      csNPin = 1'b0;
      waitClocks(halfPeriod);
   endtask

   task automatic endFrame();
      waitClocks(halfPeriod);
      csNPin = 1'b1;
      waitClocks(halfPeriod);
   endtask

   // Fewer than eight data bits aborts the frame
   task automatic writeFrame(input logic [spiMemPkg::addrWidth-1:0] addr,
                             input logic [spiMemPkg::dataWidth-1:0] data,
                             input int dataBits);
      logic [spiMemPkg::dataWidth-1:0] cmd;
      int i;
      cmd = commandByte(addr, 1'b0);
      writeWatch = 1'b1;
      startFrame();
      for (i = spiMemPkg::dataWidth - 1; i >= 0; i--) begin
         sendBit(cmd[i], kindAddr);
      end
      for (i = spiMemPkg::dataWidth - 1; i >= spiMemPkg::dataWidth - dataBits; i--) begin
         sendBit(data[i], kindNone);
      end
      endFrame();
      writeWatch = 1'b0;
      if (dataBits == spiMemPkg::dataWidth) begin
         modelWrite(addr, data);
      end
   endtask

   task automatic readFrame(input logic [spiMemPkg::addrWidth-1:0] addr, input int dataBits);
      logic [spiMemPkg::dataWidth-1:0] cmd;
      int i;
      cmd = commandByte(addr, 1'b1);
      if (!isWritten(addr)) begin
         $display("Read of address %02h that was never written", addr);
         directErrors++;
      end
      expAddr = addr;
      expByte = expectedRead(addr);
      startFrame();
      for (i = spiMemPkg::dataWidth - 1; i >= 0; i--) begin
         sendBit(cmd[i], kindAddr);
      end
      for (i = 0; i < dataBits; i++) begin
         sendBit(1'b0, kindRead);
      end
      endFrame();
      if (dataBits == spiMemPkg::dataWidth) begin
         readsIssued++;
      end
   endtask

   task automatic reportTest(input string name, input int errorsBefore);
      int newErrors;
      newErrors = totalErrors() - errorsBefore;
      testsRun++;
      if (newErrors == 0) begin
         $display("Test %s: ok", name);
      end else begin
         testsFailed++;
         $display("Test %s: %0d errors", name, newErrors);
      end
   endtask

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------
   initial begin
      logic [spiMemPkg::addrWidth-1:0] addrList [randomWrites];
      logic [spiMemPkg::addrWidth-1:0] swapAddr;
      logic [spiMemPkg::addrWidth-1:0] addrA;
      logic [spiMemPkg::addrWidth-1:0] addrG;
      int errorsBefore;
      int i;
      int j;
      void'($urandom(32'h42aa87d1));
      arstN       = 1'b0;
      sclkPin     = 1'b0;
      csNPin      = 1'b1;
      mosiPin     = 1'b0;
      sampleReq   = 1'b0;
      sampleKind  = kindNone;
      writeWatch  = 1'b0;
      glitchOn    = 1'b0;
      expAddr     = '0;
      expByte     = '0;
      readsIssued = 0;
      directErrors = 0;
      testsRun    = 0;
      testsFailed = 0;
      addrA       = 7'h2d;
      addrG       = 7'h51;
      repeat (8) @(posedge clk);
      #1;
      arstN = 1'b1;

      // Idle outputs after reset
      errorsBefore = totalErrors();
      waitClocks(halfPeriod);
      if (misoEn !== 1'b0) begin
         $display("MISMATCH at %0t: misoEn expected 0 got %b", $time, misoEn);
         directErrors++;
      end
      if (miso !== 1'b0) begin
         $display("MISMATCH at %0t: miso expected 0 got %b", $time, miso);
         directErrors++;
      end
      reportTest("reset state", errorsBefore);

      errorsBefore = totalErrors();
      writeFrame(addrA, 8'hb6, 8);
      readFrame(addrA, 8);
      reportTest("single write and read", errorsBefore);

      // Repeated addresses allowed since the model keeps the last byte
      errorsBefore = totalErrors();
      for (i = 0; i < randomWrites; i++) begin
         addrList[i] = 7'($urandom_range(spiMemPkg::memDepth - 1));
         writeFrame(addrList[i], 8'($urandom), 8);
      end
      for (i = randomWrites - 1; i > 0; i--) begin
         j = $urandom_range(i);
         swapAddr    = addrList[i];
         addrList[i] = addrList[j];
         addrList[j] = swapAddr;
      end
      for (i = 0; i < randomWrites; i++) begin
         readFrame(addrList[i], 8);
      end
      reportTest("random writes and shuffled reads", errorsBefore);

      // Aborted write and aborted read followed by a full read
      errorsBefore = totalErrors();
      writeFrame(addrA, ~expectedRead(addrA), 4);
      if (misoEn !== 1'b0) begin
         $display("MISMATCH at %0t: misoEn expected 0 got %b", $time, misoEn);
         directErrors++;
      end
      readFrame(addrA, 4);
      if (misoEn !== 1'b0) begin
         $display("MISMATCH at %0t: misoEn expected 0 got %b", $time, misoEn);
         directErrors++;
      end
      readFrame(addrA, 8);
      reportTest("aborted frames", errorsBefore);

      errorsBefore = totalErrors();
      glitchOn = 1'b1;
      writeFrame(addrG, 8'h3c, 8);
      readFrame(addrG, 8);
      readFrame(addrA, 8);
      glitchOn = 1'b0;
      reportTest("glitch rejection", errorsBefore);

      if (readsChecked != readsIssued) begin
         $display("Only %0d of %0d read bytes reached the compare process",
                  readsChecked, readsIssued);
         directErrors++;
      end
      $display("Summary: %0d tests, %0d failed, %0d errors, %0d reads compared",
               testsRun, testsFailed, totalErrors(), readsChecked);
      if (totalErrors() == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: spiMemory.f
+incdir+tb
rtl/spiMemPkg.sv
rtl/inputConditioner.sv
rtl/shiftRegister.sv
rtl/dataMemory.sv
rtl/spiController.sv
rtl/spiMemory.sv
tb/spiMemoryTb.sv

// File: build.sh
#!/bin/sh
# Build the SPI memory testbench with Verilator, run it, then scan the log
verilator --binary --timing --assert --top-module spiMemoryTb -f spiMemory.f \
   -o spiMemorySim > build.log 2>&1 \
   || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/spiMemorySim > sim.log 2>&1 \
   || echo "Simulator exited with an error status" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Verification passed" sim.log || { echo "No pass result in sim.log"; exit 1; }
echo "Simulation finished without failures"
exit 0
